// ==== list.f ====
+incdir+.
rrp_pkg.sv
rrp_digit_add.sv
rrp_partial_product.sv
rrp_mult_step.sv
rrp_mult.sv
rrp_mult_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the multiplier testbench with verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module rrp_mult_tb -f list.f -o rrp_mult_sim
./obj_dir/rrp_mult_sim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi
echo "simulation passed"

// ==== rrp_mult_tb.sv ====
// directed testbench for the pipelined signed-digit multiplier and top of the simulation
`timescale 1ns/1ps
`include "rrp_cfg.svh"

module rrp_mult_tb import rrp_pkg::*; ();

	localparam int LAT = `RRP_LATENCY;
	localparam int DMAX = `RRP_DIGIT_MAX;
	// all tests together stay well under this
	localparam int TEST_CYCLES = 600;
	localparam int CYCLE_LIMIT = 3 * TEST_CYCLES + 200;

	logic clock;
	logic rst_n;
	rrp_operand_t x_in;
	rrp_operand_t y_in;
	rrp_product_t product;

	int edge_count = 0;
	int checks = 0;
	int value_errors = 0;
	int digit_errors = 0;
	logic [31:0] lfsr;

	// expected results waiting for their output cycle
	longint exp_q[$];
	int due_q[$];
	string name_q[$];

	rrp_mult rrp_mult_i (
		.clock(clock),
		.rst_n(rst_n),
		.x_in(x_in),
		.y_in(y_in),
		.product(product)
	);

	always #5 clock = ~clock;

	// rising edges seen so far
	always @(posedge clock) begin
		edge_count <= edge_count + 1;
	end

	// fibonacci lfsr with taps 32 22 2 1
	// one step per bit
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic rrp_digit_t random_digit();
		logic [`RRP_DIGIT_BITS-1:0] raw;
		rrp_digit_t d;
		for (int b = 0; b < `RRP_DIGIT_BITS; b++) begin
			raw[b] = lfsr_bit();
		end
		d = rrp_digit_t'(raw);
		// the one pattern below the set folds to the minimum
		if (int'(d) < -DMAX) begin
			d = rrp_digit_t'(-DMAX);
		end
		return d;
	endfunction

	function automatic rrp_operand_t random_operand();
		rrp_operand_t x;
		for (int i = 0; i < `RRP_WIDTH; i++) begin
			x[i] = random_digit();
		end
		return x;
	endfunction

	// sum of digit times radix^index in horner form from the top
	function automatic longint product_value(input rrp_product_t p);
		longint v;
		rrp_digit_t d;
		v = 0;
		for (int i = RRP_PROD_DIGITS - 1; i >= 0; i--) begin
			d = p[i];
			v = v * `RRP_RADIX + longint'(d);
		end
		return v;
	endfunction

	// operand widened with zero digits on top
	function automatic longint operand_value(input rrp_operand_t x);
		rrp_product_t p;
		p = '0;
		p[`RRP_WIDTH-1:0] = x;
		return product_value(p);
	endfunction

	task automatic compare_product(input string name, input longint expected,
			input rrp_product_t actual);
		longint got;
		got = product_value(actual);
		checks++;
		if (got != expected) begin
			value_errors++;
			$display("error %s expected %0d actual %0d", name, expected, got);
		end
	endtask

	task automatic check_digits(input string name, input rrp_product_t p);
		rrp_digit_t d;
		for (int i = 0; i < RRP_PROD_DIGITS; i++) begin
			d = p[i];
			if (int'(d) > DMAX || int'(d) < -DMAX) begin
				digit_errors++;
				$display("%s: product digit %0d holds %0d, outside the digit set", name, i, d);
			end
		end
	endtask

	task automatic drop_front();
		void'(exp_q.pop_front());
		void'(due_q.pop_front());
		void'(name_q.pop_front());
	endtask

	// results are read at the falling edge well after the register update
	always @(negedge clock) begin
		if (due_q.size() != 0) begin
			if (due_q[0] == edge_count) begin
				compare_product(name_q[0], exp_q[0], product);
				check_digits(name_q[0], product);
				drop_front();
			end
		end
	end

	always @(negedge clock) begin
		if (edge_count >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, %0d results never came out",
				edge_count, due_q.size());
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic drive_pair(input string name, input rrp_operand_t x,
			input rrp_operand_t y);
		@(posedge clock);
		x_in <= x;
		y_in <= y;
		// counter still shows the previous edge here
		// product is visible LAT edges after this one
		exp_q.push_back(operand_value(x) * operand_value(y));
		due_q.push_back(edge_count + 1 + LAT);
		name_q.push_back(name);
	endtask

	task automatic wait_results();
		while (due_q.size() != 0) begin
			@(negedge clock);
		end
	endtask

	task automatic reset_zero();
		rrp_operand_t busy;
		// nonzero operands under reset must never reach the output
		for (int i = 0; i < `RRP_WIDTH; i++) begin
			busy[i] = rrp_digit_t'(DMAX);
		end
		for (int k = 1; k <= 4; k++) begin
			@(posedge clock);
			if (k == 4) begin
				rst_n <= 1'b1;
				x_in <= '0;
				y_in <= '0;
			end else begin
				x_in <= busy;
				y_in <= busy;
			end
			@(negedge clock);
			compare_product("reset_zero", 0, product);
			check_digits("reset_zero", product);
		end
		// zero operands flow through after release
		repeat (LAT) begin
			@(negedge clock);
			compare_product("reset_zero", 0, product);
			check_digits("reset_zero", product);
		end
	endtask

	task automatic corner_values();
		rrp_operand_t c [0:4];
		for (int i = 0; i < 5; i++) begin
			c[i] = '0;
		end
		c[1][0] = rrp_digit_t'(1);
		c[2][0] = rrp_digit_t'(-1);
		// all maximum and all minimum digits
		for (int i = 0; i < `RRP_WIDTH; i++) begin
			c[3][i] = rrp_digit_t'(DMAX);
			c[4][i] = rrp_digit_t'(-DMAX);
		end
		for (int a = 0; a < 5; a++) begin
			for (int b = 0; b < 5; b++) begin
				drive_pair("corner_values", c[a], c[b]);
			end
		end
		wait_results();
	endtask

	task automatic redundant_forms();
		rrp_operand_t x;
		rrp_operand_t y;
		rrp_operand_t alt;
		// 3 against 4 - 1
		x = '0;
		x[0] = rrp_digit_t'(3);
		alt = '0;
		alt[1] = rrp_digit_t'(1);
		alt[0] = rrp_digit_t'(-1);
		y = random_operand();
		drive_pair("redundant_forms", x, y);
		drive_pair("redundant_forms", alt, y);
		drive_pair("redundant_forms", y, x);
		drive_pair("redundant_forms", y, alt);
		// -1 against -radix^(width-1) plus max in every lower digit
		x = '0;
		x[0] = rrp_digit_t'(-1);
		for (int i = 0; i < `RRP_WIDTH; i++) begin
			alt[i] = rrp_digit_t'(DMAX);
		end
		alt[`RRP_WIDTH-1] = rrp_digit_t'(-1);
		drive_pair("redundant_forms", x, y);
		drive_pair("redundant_forms", alt, y);
		// random operands with one radix unit moved up a position
		for (int r = 0; r < 4; r++) begin
			x = random_operand();
			y = random_operand();
			drive_pair("redundant_forms", x, y);
			for (int i = 0; i < `RRP_WIDTH - 1; i++) begin
				alt = x;
				if (alt[i] > 0 && int'(alt[i+1]) < DMAX) begin
					alt[i] = rrp_digit_t'(int'(alt[i]) - `RRP_RADIX);
					alt[i+1] = rrp_digit_t'(int'(alt[i+1]) + 1);
					drive_pair("redundant_forms", alt, y);
				end
			end
		end
		wait_results();
	endtask

	// back-to-back random pairs with one per cycle
	task automatic stream_latency();
		repeat (200) begin
			drive_pair("stream_latency", random_operand(), random_operand());
		end
		wait_results();
	endtask

	initial begin
		clock = 1'b0;
		rst_n = 1'b0;
		x_in = '0;
		y_in = '0;
		lfsr = 32'h3b48_cb82;
		reset_zero();
		corner_values();
		redundant_forms();
		stream_latency();
		$display("checks %0d, value errors %0d, digit errors %0d",
			checks, value_errors, digit_errors);
		if (value_errors + digit_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== rrp_mult.sv ====
// top of the pipelined signed-digit multiplier, takes a new operand pair every clock
`timescale 1ns/1ps

module rrp_mult import rrp_pkg::*; (
	input logic clock,
	input logic rst_n,
	input rrp_operand_t x_in,
	input rrp_operand_t y_in,
	output rrp_product_t product
);

	localparam int N = `RRP_WIDTH;

	// chain between stages, index j feeds step j
	rrp_operand_t x_c [0:N-1];
	rrp_operand_t y_c [0:N-1];
	rrp_product_t acc_c [0:N];

	// input registers
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			x_c[0] <= '0;
			y_c[0] <= '0;
		end else begin
			x_c[0] <= x_in;
			y_c[0] <= y_in;
		end
	end

	// first step starts from a zero accumulator
	assign acc_c[0] = '0;

	genvar j;
	generate
		for (j = 0; j < N; j++) begin : g_step
			if (j < N - 1) begin : g_mid
				rrp_mult_step #(
					.STEP(j)
				) rrp_mult_step_i (
					.clock(clock),
					.rst_n(rst_n),
					.x(x_c[j]),
					.y(y_c[j]),
					.acc(acc_c[j]),
					.x_q(x_c[j+1]),
					.y_q(y_c[j+1]),
					.acc_q(acc_c[j+1])
				);
			end else begin : g_last
				// operands are not needed past the last digit of y
				rrp_mult_step #(
					.STEP(j)
				) rrp_mult_step_i (
					.clock(clock),
					.rst_n(rst_n),
					.x(x_c[j]),
					.y(y_c[j]),
					.acc(acc_c[j]),
					.x_q(),
					.y_q(),
					.acc_q(acc_c[j+1])
				);
			end
		end
	endgenerate

	// output register, exact product still in redundant form
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			product <= '0;
		end else begin
			product <= acc_c[N];
		end
	end

endmodule

// ==== rrp_mult_step.sv ====
// one pipeline stage of the multiplier, adds the shifted partial product for digit STEP of y
`timescale 1ns/1ps

module rrp_mult_step import rrp_pkg::*; #(
	parameter int STEP = 0
) (
	input logic clock,
	input logic rst_n,
	input rrp_operand_t x,
	input rrp_operand_t y,
	input rrp_product_t acc,
	output rrp_operand_t x_q,
	output rrp_operand_t y_q,
	output rrp_product_t acc_q
);

	// the digit of y this stage consumes
	rrp_digit_t y_d;

	rrp_pprod_t pp;
	rrp_product_t pp_wide;
	rrp_product_t acc_next;

	assign y_d = y[STEP];

	// x times one digit of y
	rrp_partial_product rrp_partial_product_i (
		.x(x),
		.d(y_d),
		.pp(pp)
	);

	// place pp at weight radix^STEP
	// STEP + width + 1 digits still fit inside the product vector
	always_comb begin
		pp_wide = '0;
		pp_wide[STEP +: `RRP_WIDTH+1] = pp;
	end

	// accumulate without a carry chain
	rrp_digit_add rrp_digit_add_i (
		.a(acc),
		.b(pp_wide),
		.sum(acc_next)
	);

	// operands move along with their partial sum
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			x_q <= '0;
			y_q <= '0;
			acc_q <= '0;
		end else begin
			x_q <= x;
			y_q <= y;
			acc_q <= acc_next;
		end
	end

endmodule

// ==== rrp_partial_product.sv ====
// operand vector times one digit, giving a redundant partial product one digit wider
`timescale 1ns/1ps

module rrp_partial_product import rrp_pkg::*; (
	input rrp_operand_t x,
	input rrp_digit_t d,
	output rrp_pprod_t pp
);

	localparam int N = `RRP_WIDTH;

	// high and low digits of each digit product
	rrp_digit_t hi [0:N-1];
	rrp_digit_t lo [0:N-1];

	// xfer[i] is the transfer into pp position i
	rrp_xfer_t xfer [0:N];

	assign xfer[0] = 2'sb00;

	genvar i;
	generate
		for (i = 0; i < N; i++) begin : g_split
			rrp_digit_t x_d;
			rrp_dprod_t prod;
			rrp_dprod_t hi_full;

			assign x_d = x[i];

			// |prod| <= (radix-1)^2
			assign prod = x_d * d;

			// round to nearest radix multiple
			// gives |hi| <= radix-2 and |lo| <= radix/2
			assign hi_full = (prod + RRP_HALF_RADIX) >>> RRP_LOG2_RADIX;
			assign hi[i] = rrp_digit_t'(hi_full);
			assign lo[i] = rrp_digit_t'(prod - (hi_full <<< RRP_LOG2_RADIX));
		end

		for (i = 0; i < N; i++) begin : g_merge
			rrp_dsum_t s;

			// low digit of i plus high digit from i-1
			if (i == 0) begin : g_first
				assign s = lo[i];
			end else begin : g_rest
				assign s = lo[i] + hi[i-1];
			end

			// same transfer rule as the adder
			assign xfer[i+1] = rrp_transfer(s);
			assign pp[i] = rrp_interim(s) + rrp_digit_t'(xfer[i]);
		end
	endgenerate

	// top digit holds only the last high digit
	// |hi| <= radix-2, so adding a transfer stays legal
	assign pp[N] = hi[N-1] + rrp_digit_t'(xfer[N]);

endmodule

// ==== rrp_digit_add.sv ====
// carry-free adder of two product-wide digit vectors, used by every multiply step
`timescale 1ns/1ps

module rrp_digit_add import rrp_pkg::*; (
	input rrp_product_t a,
	input rrp_product_t b,
	output rrp_product_t sum
);

	localparam int N = RRP_PROD_DIGITS;

	// xfer[i] is the transfer into position i
	rrp_xfer_t xfer [0:N-1];

	// nothing comes in below digit 0
	assign xfer[0] = 2'sb00;

	genvar i;
	generate
		for (i = 0; i < N; i++) begin : g_pos
			rrp_digit_t a_d;
			rrp_digit_t b_d;
			rrp_dsum_t s;

			// pull the digits out as signed values
			assign a_d = a[i];
			assign b_d = b[i];

			// raw position sum, range is twice the digit set
			assign s = a_d + b_d;

			if (i < N - 1) begin : g_mid
				rrp_digit_t w;

				// split into transfer up and interim digit kept
				assign xfer[i+1] = rrp_transfer(s);
				assign w = rrp_interim(s);

				// interim plus transfer from below, back in the digit set
				assign sum[i] = w + rrp_digit_t'(xfer[i]);
			end else begin : g_top
				rrp_digit_t w;

				// top position never transfers
				// the accumulated value stays below radix^(2*width)
				// so the top sum is at most radix-2 in magnitude
				assign w = rrp_digit_t'(s);
				assign sum[i] = w + rrp_digit_t'(xfer[i]);
			end
		end
	endgenerate

	// every output digit depends only on positions i and i-1
	// delay does not grow with the width

endmodule

// ==== rrp_pkg.sv ====
// digit and vector types plus the shared transfer rule, imported by every multiplier module
`include "rrp_cfg.svh"

package rrp_pkg;

	// one two's-complement digit
	typedef logic signed [`RRP_DIGIT_BITS-1:0] rrp_digit_t;

	// operand, partial product and product as packed digit vectors
	typedef rrp_digit_t [`RRP_WIDTH-1:0] rrp_operand_t;
	typedef rrp_digit_t [`RRP_WIDTH:0] rrp_pprod_t;
	typedef rrp_digit_t [2*`RRP_WIDTH:0] rrp_product_t;

	// sum of two digits needs one extra bit
	typedef logic signed [`RRP_DIGIT_BITS:0] rrp_dsum_t;

	// product of two digits needs twice the digit width
	typedef logic signed [2*`RRP_DIGIT_BITS-1:0] rrp_dprod_t;

	// transfer digit, only -1, 0 or +1
	typedef logic signed [1:0] rrp_xfer_t;

	localparam int RRP_LOG2_RADIX = $clog2(`RRP_RADIX);
	localparam int RRP_PROD_DIGITS = 2*`RRP_WIDTH + 1;
	localparam rrp_dsum_t RRP_DSUM_MAX = rrp_dsum_t'(`RRP_DIGIT_MAX);
	localparam rrp_dprod_t RRP_HALF_RADIX = rrp_dprod_t'(`RRP_RADIX / 2);

	// transfer out of one position
	// |sum| >= radix-1 moves one radix unit up, which leaves |interim| <= radix-2
	function automatic rrp_xfer_t rrp_transfer(input rrp_dsum_t s);
		rrp_xfer_t t;
		if (s >= RRP_DSUM_MAX) begin
			t = 2'sb01;
		end else if (s <= -RRP_DSUM_MAX) begin
			t = 2'sb11;
		end else begin
			t = 2'sb00;
		end
		return t;
	endfunction

	// interim digit, sum minus transfer times radix
	// small enough that adding the incoming transfer stays in the digit set
	function automatic rrp_digit_t rrp_interim(input rrp_dsum_t s);
		rrp_dsum_t w;
		w = s - (rrp_dsum_t'(rrp_transfer(s)) <<< RRP_LOG2_RADIX);
		return rrp_digit_t'(w);
	endfunction

endpackage

// ==== rrp_cfg.svh ====
// size macros for the signed-digit multiplier, included by the package, the rtl and the testbench
`ifndef RRP_CFG_SVH
`define RRP_CFG_SVH

// digits per operand, index 0 is the least significant digit
`define RRP_WIDTH 8

// radix, a power of two above 2
`define RRP_RADIX 4

// one sign bit on top of log2 of the radix
`define RRP_DIGIT_BITS ($clog2(`RRP_RADIX) + 1)

// maximally redundant digit set runs from -(radix-1) to radix-1
`define RRP_DIGIT_MAX (`RRP_RADIX - 1)

// input register, one cycle per multiply step, output register
// counted from the edge the operands are driven on
`define RRP_LATENCY (`RRP_WIDTH + 2)

`endif
